/* include/cart_loader_defs.svh */
////////////////////////////////////////////////////////////
// Shared constants for the cartridge loading front end
// Include wherever widths or header offsets are needed
////////////////////////////////////////////////////////////

`ifndef CART_LOADER_DEFS_SVH
`define CART_LOADER_DEFS_SVH

// Download stream widths
`define CART_ADDR_W        25       // Byte address from the host
`define ROM_ADDR_W         24       // Word address into ROM
`define DL_DATA_W          16

// Region field of the cartridge header
`define HDR_REGION_ADDR    25'h1F0
`define HDR_REGION2_ADDR   25'h1F2
`define HDR_END_ADDR       25'h200  // First word past the header

// Serial number words
`define SERIAL_FIRST_ADDR  25'h182
`define SERIAL_LAST_ADDR   25'h18A
`define SERIAL_DONE_ADDR   25'h18C

// Light gun sensor delay when the title is not listed
`define GUN_DELAY_DEFAULT  8'd44

// Cheat record, clock bit on top of four 32-bit words
`define CHEAT_W            129

`endif

/* logic/cart_pkg.sv */
////////////////////////////////////////////////////////////
// Cartridge level types
// Region codes, compatibility flags and light gun profile
////////////////////////////////////////////////////////////

package cart_pkg;

	// Console region as seen by the core
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	// Per-title compatibility flags
	typedef struct packed {
		logic sram;    // Forced SRAM mapping
		logic sram00;  // SRAM at bank 0
		logic eeprom;  // Serial EEPROM save
		logic fifo;    // Fast VDP FIFO
		logic noram;   // Hide fake RAM
		logic pier;    // Pier Solar mapper
		logic svp;     // SVP chip present
		logic fmbusy;  // YM busy flag timing
		logic schan;   // Game no Kanzume mapper
	} quirk_t;

	// Light gun device type and sensor timing
	typedef struct packed {
		logic       gun_type;     // 1 for the Justifier reload style
		logic [7:0] sensor_delay;
	} gun_profile_t;

endpackage

/* logic/loader_pkg.sv */
////////////////////////////////////////////////////////////
// Download level types
// Region selection options and the cheat record layout
////////////////////////////////////////////////////////////

`include "cart_loader_defs.svh"

package loader_pkg;

	// Where the region comes from
	typedef enum logic {
		MODE_HEADER,
		MODE_DISABLED
	} region_mode_e;

	// Search order over the header region letters
	typedef enum logic [1:0] {
		PRIO_US_EU_JP,
		PRIO_EU_US_JP,
		PRIO_US_JP_EU,
		PRIO_JP_US_EU
	} region_prio_e;

	typedef logic [(`CHEAT_W-1)/4-1:0] cheat_word_t;

	// Fields are big endian words as sent by the code generator
	typedef struct packed {
		cheat_word_t flags;
		cheat_word_t address;
		cheat_word_t compare;
		cheat_word_t replace;
	} cheat_t;

endpackage

/* logic/cart_dl_if.sv */
////////////////////////////////////////////////////////////
// Decoded host download stream shared by the loader blocks
// Top drives the strobes, the pacer adds the edge pulses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

interface cart_dl_if;

	logic                    cart_wr;     // ROM image word
	logic                    code_wr;     // Cheat code word
	logic [`CART_ADDR_W-1:0] addr;
	logic [`DL_DATA_W-1:0]   data;
	logic                    cart_active;
	logic                    cart_start;  // Download begins
	logic                    cart_end;    // Download ends

	modport source (
		input  cart_wr, addr, data, cart_active,
		output cart_start, cart_end
	);

	modport sink (
		input cart_wr, code_wr, addr, data, cart_active, cart_start, cart_end
	);

endinterface

/* logic/rom_write_pacer.sv */
////////////////////////////////////////////////////////////
// Paces cartridge words into ROM with a toggle handshake
// Holds the host with dl_wait and records the ROM size
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module rom_write_pacer (
	input  logic                    clk_sys,
	input  logic                    RESET,
	cart_dl_if.source               dl,
	output logic [`ROM_ADDR_W-1:0]  rom_addr,
	output logic [`DL_DATA_W-1:0]   rom_wdata,
	output logic                    rom_req,
	input  logic                    rom_ack,
	output logic                    dl_wait,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic active_q;

	// Download edges, used by every worker
	assign dl.cart_start = dl.cart_active & ~active_q;
	assign dl.cart_end   = ~dl.cart_active & active_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_q <= 1'b0;
			rom_req  <= 1'b0;
			dl_wait  <= 1'b0;
		end else begin
			active_q <= dl.cart_active;
			if (dl.cart_wr) begin
				rom_req <= ~rom_req; // New request
				dl_wait <= 1'b1;
			end else if (dl_wait && (rom_ack == rom_req)) begin
				dl_wait <= 1'b0;     // Memory caught up
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl.cart_wr) begin
			rom_addr  <= dl.addr[`CART_ADDR_W-1:1];
			rom_wdata <= {dl.data[`DL_DATA_W/2-1:0], dl.data[`DL_DATA_W-1:`DL_DATA_W/2]};
		end
		if (dl.cart_end)
			rom_size <= dl.addr; // Last byte address of the image
	end

	// Host honours back-pressure
	a_no_write_while_wait: assert property (
		@(posedge clk_sys) disable iff (RESET) dl_wait |-> !dl.cart_wr
	) else $error("cart_wr while dl_wait is high");

endmodule

/* logic/header_region_detect.sv */
////////////////////////////////////////////////////////////
// Reads the header region field during a download
// Requests a region by priority once the header is in
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module header_region_detect
	import cart_pkg::*;
	import loader_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	cart_dl_if.sink      dl,
	input  region_mode_e region_mode,
	input  region_prio_e region_prio,
	output region_e      region_req,
	output logic         region_set
);

	logic [2:0] hdr_flags;  // {e, u, j}
	logic [2:0] next_flags;
	logic [3:0] hrgn;
	logic       hdr_ready;
	logic       ready_q;

	// Letter form of the field
	function automatic logic [2:0] letter_bits(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	function automatic region_e pick_region(input region_prio_e prio, input logic [2:0] found);
		region_e order [3];
		region_e pick;
		case (prio)
			PRIO_US_EU_JP: order = '{REGION_US, REGION_EU, REGION_JP};
			PRIO_EU_US_JP: order = '{REGION_EU, REGION_US, REGION_JP};
			PRIO_US_JP_EU: order = '{REGION_US, REGION_JP, REGION_EU};
			default:       order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0]; // Nothing present
		for (int i = 2; i >= 0; i--)
			if (found[order[i]])
				pick = order[i];
		return pick;
	endfunction

	assign hrgn = dl.data[3:0] - 4'd7; // 'A'..'F' to 10..15

	always_comb begin
		next_flags = hdr_flags;
		if (dl.addr == `HDR_REGION_ADDR) begin
			if (letter_bits(dl.data[7:0]) != 3'b000)
				next_flags = next_flags | letter_bits(dl.data[7:0]);
			else if (dl.data[7:0] >= "0" && dl.data[7:0] <= "9")
				next_flags = {dl.data[3], dl.data[2], dl.data[0]}; // Hex digit, bit per region
			else if (dl.data[7:0] >= "A" && dl.data[7:0] <= "F")
				next_flags = {hrgn[3], hrgn[2], hrgn[0]};
			next_flags = next_flags | letter_bits(dl.data[15:8]);
		end
		if (dl.addr == `HDR_REGION2_ADDR)
			next_flags = next_flags | letter_bits(dl.data[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_flags  <= 3'b000;
			hdr_ready  <= 1'b0;
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (dl.cart_start)
				hdr_flags <= 3'b000;
			else if (dl.cart_wr)
				hdr_flags <= next_flags;
			if (dl.cart_wr && dl.addr == `HDR_END_ADDR)
				hdr_ready <= 1'b1;
			// Header complete, choose once
			if (hdr_ready && !ready_q && region_mode == MODE_HEADER) begin
				region_req <= pick_region(region_prio, hdr_flags);
				region_set <= 1'b1;
			end
			if (dl.cart_end) begin
				hdr_ready  <= 1'b0;
				region_set <= 1'b0;
			end
		end
	end

	a_region_legal: assert property (
		@(posedge clk_sys) disable iff (RESET) region_req inside {REGION_JP, REGION_US, REGION_EU}
	) else $error("region_req holds an undefined region");

endmodule

/* logic/cart_id_quirks.sv */
////////////////////////////////////////////////////////////
// Captures the cartridge serial from the header
// Raises compatibility flags and the light gun profile
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module cart_id_quirks
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	cart_dl_if.sink      dl,
	output quirk_t       quirks,
	output gun_profile_t gun_profile
);

	logic [63:0] cart_id; // Eight ASCII characters

	function automatic quirk_t quirk_lookup(input logic [63:0] id);
		quirk_t q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ", "T-081586", "T-81576 ": q.sram   = 1'b1;
			"MK-1215 ", "G-4060  ", "00001211", "T-12046 ": q.eeprom = 1'b1;
			"T-113016":                                     q.noram  = 1'b1; // Puggsy
			"T-89016 ":                                     q.fifo   = 1'b1; // Clue
			"T-574023", "T-574013":                         q.pier   = 1'b1;
			"MK-1229 ", "G-7001  ":                         q.svp    = 1'b1; // Virtua Racing
			"T-35036 ", "T-25073 ", "MK-1137-":             q.fmbusy = 1'b1; // Hellfire
			" GM 0000":                                     q.sram00 = 1'b1;
			default:                                        q = '0;
		endcase
		// Any T-68xxx- serial uses the Kanzume mapper
		if (id[63:32] == "T-68" && id[7:0] == "-")
			q.schan = 1'b1;
		return q;
	endfunction

	function automatic gun_profile_t gun_lookup(input logic [63:0] id);
		case (id)
			"MK-1533 ": return '{gun_type: 1'b0, sensor_delay: 8'd100}; // Body Count
			"T-95096-": return '{gun_type: 1'b1, sensor_delay: 8'd52};
			"T-95136-": return '{gun_type: 1'b1, sensor_delay: 8'd30};
			"MK-1658 ": return '{gun_type: 1'b0, sensor_delay: 8'd120}; // Menacer 6-in-1
			default:    return '{gun_type: 1'b0, sensor_delay: `GUN_DELAY_DEFAULT};
		endcase
	endfunction

	// Serial bytes arrive swapped within each word
	always_ff @(posedge clk_sys) begin
		if (dl.cart_wr) begin
			case (dl.addr)
				`SERIAL_FIRST_ADDR:          cart_id[63:56] <= dl.data[15:8];
				`SERIAL_FIRST_ADDR + 25'd2:  cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				`SERIAL_FIRST_ADDR + 25'd4:  cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				`SERIAL_FIRST_ADDR + 25'd6:  cart_id[23:8]  <= {dl.data[7:0], dl.data[15:8]};
				`SERIAL_LAST_ADDR:           cart_id[7:0]   <= dl.data[7:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks      <= '0;
			gun_profile <= '{gun_type: 1'b0, sensor_delay: `GUN_DELAY_DEFAULT};
		end else if (dl.cart_start) begin
			quirks <= '0;
		end else if (dl.cart_wr && dl.addr == `SERIAL_DONE_ADDR) begin
			quirks      <= quirk_lookup(cart_id);
			gun_profile <= gun_lookup(cart_id);
		end
	end

	a_one_quirk_class: assert property (
		@(posedge clk_sys) disable iff (RESET) $onehot0(quirks)
	) else $error("More than one quirk class set for a serial");

endmodule

/* logic/cheat_code_assembler.sv */
////////////////////////////////////////////////////////////
// Builds cheat records from the code download stream
// Pulses cheat_valid per record, cheat_clear on offset 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module cheat_code_assembler
	import loader_pkg::*;
(
	input  logic    clk_sys,
	input  logic    RESET,
	cart_dl_if.sink dl,
	output cheat_t  cheat_code,
	output logic    cheat_valid,
	output logic    cheat_clear
);

	logic [`CHEAT_W-2:0] payload;
	logic [6:0]          word_pos;

	// Offset 0,2 flags, 4,6 address, 8,10 compare, 12,14 replace
	// Low half of each field comes first
	assign word_pos = {~dl.addr[3:2], dl.addr[1], 4'b0000};

	always_ff @(posedge clk_sys) begin
		if (dl.code_wr)
			payload[word_pos +: `DL_DATA_W] <= dl.data;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= dl.code_wr && dl.addr[3:0] == 4'd14; // Replace top word closes it
			cheat_clear <= dl.code_wr && dl.addr == '0;         // New code list
		end
	end

	assign cheat_code = payload;

endmodule

/* logic/cart_loader_top.sv */
////////////////////////////////////////////////////////////
// Cartridge loading front end of the console core
// Splits the host stream by index and wires the workers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module cart_loader_top
	import cart_pkg::*;
	import loader_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    dl_active,
	input  logic [7:0]              dl_index,
	input  logic                    dl_wr,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`DL_DATA_W-1:0]   dl_data,
	output logic                    dl_wait,
	output logic [`ROM_ADDR_W-1:0]  rom_addr,
	output logic [`DL_DATA_W-1:0]   rom_wdata,
	output logic                    rom_req,
	input  logic                    rom_ack,
	output logic [`CART_ADDR_W-1:0] rom_size,
	input  region_mode_e            region_mode,
	input  region_prio_e            region_prio,
	output region_e                 region_req,
	output logic                    region_set,
	output quirk_t                  quirks,
	output gun_profile_t            gun_profile,
	output cheat_t                  cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_clear
);

	logic code_index; // All-ones index carries cheat codes

	cart_dl_if dl ();

	assign code_index     = &dl_index;
	assign dl.cart_active = dl_active & ~code_index;
	assign dl.cart_wr     = dl_wr & dl_active & ~code_index;
	assign dl.code_wr     = dl_wr & dl_active & code_index;
	assign dl.addr        = dl_addr;
	assign dl.data        = dl_data;

	rom_write_pacer i_rom_write_pacer (
		.clk_sys, .RESET, .dl(dl.source),
		.rom_addr, .rom_wdata, .rom_req, .rom_ack, .dl_wait, .rom_size
	);

	header_region_detect i_header_region_detect (
		.clk_sys, .RESET, .dl(dl.sink),
		.region_mode, .region_prio, .region_req, .region_set
	);

	cart_id_quirks i_cart_id_quirks (
		.clk_sys, .RESET, .dl(dl.sink), .quirks, .gun_profile
	);

	cheat_code_assembler i_cheat_code_assembler (
		.clk_sys, .RESET, .dl(dl.sink), .cheat_code, .cheat_valid, .cheat_clear
	);

endmodule

/* verif/cart_loader_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for the cartridge loading front end
// Replays the testdata records against the DUT
// and models the ROM side of the toggle handshake
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "cart_loader_defs.svh"

module cart_loader_tb
	import cart_pkg::*;
	import loader_pkg::*;
();

	localparam int WAIT_LIMIT = 64; // Well above the longest ack delay

	logic                    clk_sys;
	logic                    RESET;
	logic                    dl_active;
	logic [7:0]              dl_index;
	logic                    dl_wr;
	logic [`CART_ADDR_W-1:0] dl_addr;
	logic [`DL_DATA_W-1:0]   dl_data;
	logic                    dl_wait;
	logic [`ROM_ADDR_W-1:0]  rom_addr;
	logic [`DL_DATA_W-1:0]   rom_wdata;
	logic                    rom_req;
	logic                    rom_ack = 1'b0;
	logic [`CART_ADDR_W-1:0] rom_size;
	region_mode_e            region_mode;
	region_prio_e            region_prio;
	region_e                 region_req;
	logic                    region_set;
	quirk_t                  quirks;
	gun_profile_t            gun_profile;
	cheat_t                  cheat_code;
	logic                    cheat_valid;
	logic                    cheat_clear;

	logic [31:0]  lfsr_state = 32'h3bc12788;
	logic [39:0]  rom_expect [$];  // {word address, swapped data}
	logic [39:0]  rom_seen;
	int           ack_delay = 0;
	int           words_written = 0;
	int           words_accepted = 0;
	logic [31:0]  valid_count = '0;
	logic [31:0]  clear_count = '0;
	int           fd;
	logic [7:0]   tok;
	logic [959:0] skip_line;
	logic [31:0]  fields [6];

	cart_loader_top i_cart_loader_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////
	// Error reporting and random delays

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_mismatch(input string what);
		stop_run($sformatf("Mismatch at time %0t: %s", $time, what));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits[i]    = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state); // One step per bit
		end
		return bits;
	endfunction

	////////////////////////////////////////////////////////////
	// ROM model answering each request toggle after 0 to 7 cycles

	always @(negedge clk_sys) begin
		if (RESET) begin
			ack_delay = 0;
		end else if (ack_delay > 0) begin
			ack_delay--;
			if (ack_delay == 0)
				rom_ack = rom_req;
		end else if (rom_req != rom_ack) begin
			if (rom_expect.size() == 0) begin
				stop_run("ROM request seen with no host write outstanding");
			end else begin
				rom_seen = rom_expect.pop_front();
				assert (rom_addr == rom_seen[39:16] && rom_wdata == rom_seen[15:0])
					else report_mismatch($sformatf("ROM write %h/%h, expected %h/%h",
						rom_addr, rom_wdata, rom_seen[39:16], rom_seen[15:0]));
				words_accepted++;
				ack_delay = take_bits(3);
				if (ack_delay == 0)
					rom_ack = rom_req; // Same cycle answer
			end
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (cheat_valid)
				valid_count++;
			if (cheat_clear)
				clear_count++;
		end
	end

	////////////////////////////////////////////////////////////
	// Host side

	task automatic write_cart_word(input logic [24:0] addr, input logic [15:0] data);
		int wait_cycles;
		rom_expect.push_back({addr[24:1], data[7:0], data[15:8]});
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		words_written++;
		assert (dl_wait) else report_mismatch("dl_wait low on the cycle after a write");
		wait_cycles = 0;
		while (dl_wait) begin
			if (wait_cycles == WAIT_LIMIT) begin
				stop_run("Timeout waiting for dl_wait to clear");
			end else begin
				wait_cycles++;
				@(negedge clk_sys);
			end
		end
		assert (rom_ack == rom_req) else report_mismatch("dl_wait cleared before the ROM ack");
	endtask

	task automatic write_code_word(input logic [24:0] addr, input logic [15:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic read_fields(input int count);
		for (int i = 0; i < count; i++)
			if ($fscanf(fd, "%h", fields[i]) != 1)
				stop_run("A testdata record is missing a field");
	endtask

	task automatic run_records();
		while ($fscanf(fd, "%s", tok) == 1) begin
			case (tok)
				"#": void'($fgets(skip_line, fd)); // Rest of the line is a comment
				"R": begin
					read_fields(2);
					region_mode = region_mode_e'(fields[0][0]);
					region_prio = region_prio_e'(fields[1][1:0]);
					@(negedge clk_sys);
				end
				"B": begin
					dl_index  = 8'h00;
					dl_active = 1'b1;
					@(negedge clk_sys);
				end
				"C": begin
					dl_index    = 8'hFF;
					dl_active   = 1'b1;
					valid_count = '0;
					clear_count = '0;
					@(negedge clk_sys);
				end
				"W": begin
					read_fields(2);
					write_cart_word(fields[0][24:0], fields[1][15:0]);
				end
				"K": begin
					read_fields(2);
					write_code_word(fields[0][24:0], fields[1][15:0]);
				end
				"E": begin
					dl_active = 1'b0;
					repeat (2) @(negedge clk_sys); // Size is latched on the falling edge
				end
				"S": begin
					read_fields(1);
					assert (rom_size == fields[0][24:0])
						else report_mismatch($sformatf("rom_size %h, expected %h",
							rom_size, fields[0][24:0]));
				end
				"G": begin
					read_fields(2);
					assert (region_req == region_e'(fields[0][1:0]) && region_set == fields[1][0])
						else report_mismatch($sformatf("region %0d set %b, expected %0d set %b",
							region_req, region_set, fields[0][1:0], fields[1][0]));
				end
				"Q": begin
					read_fields(2);
					assert (quirks == quirk_t'(fields[0][8:0])
						&& gun_profile == gun_profile_t'(fields[1][8:0]))
						else report_mismatch($sformatf("quirks %h gun %h, expected %h gun %h",
							quirks, gun_profile, fields[0][8:0], fields[1][8:0]));
				end
				"V": begin
					read_fields(6);
					repeat (2) @(negedge clk_sys);
					assert (cheat_code == {fields[0], fields[1], fields[2], fields[3]})
						else report_mismatch($sformatf("cheat_code %h", cheat_code));
					assert (valid_count == fields[4] && clear_count == fields[5])
						else report_mismatch($sformatf("%0d valid and %0d clear pulses",
							valid_count, clear_count));
				end
				default: stop_run("Unknown record letter in the testdata file");
			endcase
		end
	endtask

	initial begin
		dl_active   = 1'b0;
		dl_index    = 8'h00;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		region_mode = MODE_HEADER;
		region_prio = PRIO_US_EU_JP;
		RESET       = 1'b1;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		assert (!dl_wait && !region_set && !cheat_valid && !cheat_clear && quirks == '0
			&& gun_profile == gun_profile_t'({1'b0, `GUN_DELAY_DEFAULT}) && rom_req == rom_ack)
			else report_mismatch("outputs not in their reset state");
		fd = $fopen("verif/cart_loader_testdata.txt", "r");
		if (fd == 0) begin
			stop_run("Cannot open the testdata file");
		end else begin
			run_records();
			$fclose(fd);
			dl_active = 1'b0;
			assert (words_accepted == words_written && rom_expect.size() == 0)
				else report_mismatch($sformatf("%0d words written, %0d accepted",
					words_written, words_accepted));
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

/* genesis_cart_loader.f */
+incdir+include
logic/cart_pkg.sv
logic/loader_pkg.sv
logic/cart_dl_if.sv
logic/rom_write_pacer.sv
logic/header_region_detect.sv
logic/cart_id_quirks.sv
logic/cheat_code_assembler.sv
logic/cart_loader_top.sv
verif/cart_loader_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= genesis_cart_loader.f
TOP       ?= cart_loader_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/cart_loader_testdata.txt */
# Letter then hex fields: R mode prio, B begin, W addr data, E end, S size, G region set,
# Q quirks gun, C code begin, K addr data, V flags address compare replace valid clear
R 0 0      # Header mode, US EU JP
B
W 182 4D20 # Serial MK-1229, SVP title
W 184 2D4B
W 186 3231
W 188 3932
W 18A 2020
W 18C 0000
Q 004 02C
W 1F0 454A # Letters J and E
W 200 0000
G 2 1
W 3FE 1234
E
S 3FE
G 2 0
R 0 3      # JP US EU
B
W 182 5420 # Serial T-95096-, reload style gun
W 184 392D
W 186 3035
W 188 3639
W 18A 202D
W 18C 0000
Q 000 134
W 1F0 2034 # Hex digit 4, US only
W 200 0000
G 1 1
E
S 200
G 1 0
R 1 1      # Region detection off
B
W 182 5420 # Serial T-99999 not listed
W 184 392D
W 186 3939
W 188 3939
W 18A 2020
W 18C 0000
Q 000 02C
W 1F0 2043
W 200 0000
G 1 0
E
S 200
C
K 0 0001
K 2 0000
K 4 1234
K 6 00FF
K 8 5678
K A 0000
K C ABCD
K E 0000
V 00000001 00FF1234 00005678 0000ABCD 1 1
